// ==== sim/cam_stimulus.txt ====
// opcode arg1 arg0 pay1 pay0 model expected_pay1 expected_pay0
// model is the adc sdo word, or data0/data1 of the addressed i2c board
00 12 34 00 00 0000 aa 55   // test word
10 00 00 11 22 0000 23 d0   // version
06 5a a5 c3 3c 0000 c3 3c   // echo
2f 01 02 77 88 0000 77 88   // unknown opcode, echo
04 00 00 00 00 0000 00 00   // acquisition on
01 a5 3c 00 00 beef be ef   // adc exchange
02 00 00 5e 5f 0000 5e 5f   // adc sync
03 00 00 45 67 0000 45 67   // fifo reset
07 48 10 9a bc 1357 9a bc   // power board write
08 48 02 00 00 c0de c0 de   // power board read
09 36 04 00 00 4d2a 4d 2a   // power board read, repeated start
0a 1e 20 11 00 8888 11 00   // sensor board write
0b 1e 21 00 00 f00d f0 0d   // sensor board read
0c 1e 22 00 00 0a5b 0a 5b   // sensor board read, repeated start
0d 55 06 12 34 abcd 12 34   // fuel gauge word write
05 00 00 00 00 0000 00 00   // acquisition off
01 00 ff 99 99 6c39 6c 39   // adc exchange again

// ==== vlog.f ====
logic/cam_pkg.sv
logic/host_link.sv
logic/cam_dispatch.sv
logic/adc_spi_port.sv
logic/i2c_request.sv
logic/cam_top.sv
sim/cam_checker.sv
sim/tb_cam.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cam link testbench with verilator, from the project root
verilator --binary --timing --assert -Wno-fatal --top-module tb_cam -f vlog.f -o sim_cam \
	|| { echo "build failed"; exit 1; }
./obj_dir/sim_cam > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== sim/tb_cam.sv ====
`timescale 1ns/100ps

module tb_cam;
	import cam_pkg::*;

	localparam int CLK_NS = 40;
	localparam int DRIVE_NS = 2;            // input skew after the rising edge
	localparam int SCK_HALF = 8;            // clk cycles per host sck half period
	localparam int FIELDS = 8;              // words per stimulus line
	localparam int MAX_FRAMES = 64;

	logic clk;
	logic n_reset;
	logic sck;
	logic din;
	logic dout;
	logic ready;
	adc_pins_t adc;
	logic adc_sdo;
	logic spi_fifo_rst;
	logic acq_en;
	i2c_req_t i2c_req;
	i2c_rsp_t i2c_pb;
	i2c_rsp_t i2c_sns;

	logic [15:0] stim [0:MAX_FRAMES*FIELDS-1];
	int n_frames = 0;
	cam_frame_t sent;                       // frame on the wire now
	logic [15:0] model_word;                // adc sdo word or i2c data0/data1
	logic [15:0] exp_pay;
	logic frame_start;
	int errors;
	int checked;
	logic [31:0] lfsr = 32'hd7cc_5670;

	cam_top dut0 (
		.clk          (clk),
		.n_reset      (n_reset),
		.sck          (sck),
		.din          (din),
		.dout         (dout),
		.ready        (ready),
		.adc          (adc),
		.adc_sdo      (adc_sdo),
		.spi_fifo_rst (spi_fifo_rst),
		.acq_en       (acq_en),
		.i2c_req      (i2c_req),
		.i2c_pb       (i2c_pb),
		.i2c_sns      (i2c_sns)
	);

	cam_checker chk0 (
		.clk          (clk),
		.n_reset      (n_reset),
		.sck          (sck),
		.dout         (dout),
		.ready        (ready),
		.adc          (adc),
		.spi_fifo_rst (spi_fifo_rst),
		.acq_en       (acq_en),
		.i2c_req      (i2c_req),
		.frame_start  (frame_start),
		.sent         (sent),
		.exp_pay      (exp_pay),
		.errors       (errors),
		.checked      (checked)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output int val);
		val = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);        // one step per bit taken
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic clk_wait();
		@(posedge clk);
		#DRIVE_NS;
	endtask

	// ------------------------------
	// host side bit-banging
	task automatic host_bit(input logic b);
		din = b;                            // set up during sck low
		repeat (SCK_HALF) clk_wait();
		sck = 1'b1;
		repeat (SCK_HALF) clk_wait();
		sck = 1'b0;
	endtask

	task automatic run_frame(input int idx);
		int base;
		base = idx * FIELDS;
		sent.stx = 8'h02;
		sent.opcode = stim[base][7:0];
		sent.arg1 = stim[base+1][7:0];
		sent.arg0 = stim[base+2][7:0];
		sent.pay1 = stim[base+3][7:0];
		sent.pay0 = stim[base+4][7:0];
		sent.cs = sent.opcode ^ sent.arg1 ^ sent.arg0 ^ sent.pay1 ^ sent.pay0;
		sent.etx = 8'h03;
		model_word = stim[base+5];
		exp_pay = {stim[base+6][7:0], stim[base+7][7:0]};
		frame_start = 1'b1;                 // checker clears its per-frame counts
		clk_wait();
		frame_start = 1'b0;
		for (int b = MSG_LENGTH - 1; b >= 0; b--)
			host_bit(sent[b]);              // msb first
		while (!ready)
			clk_wait();                     // watchdog bounds this
		repeat (MSG_LENGTH)
			host_bit(1'b0);                 // clock the response out
		repeat (4) clk_wait();
	endtask

	// ------------------------------
	// adc model, next sdo bit after every sck fall
	initial begin : adc_model
		adc_pins_t prev;
		logic [15:0] sdo_shift;
		prev = '0;
		prev.n_cs = 1'b1;
		sdo_shift = '0;
		adc_sdo = 1'b0;
		forever begin
			clk_wait();
			if (prev.n_cs && !adc.n_cs)
				sdo_shift = model_word;     // msb out at n_cs fall
			else if (prev.sck && !adc.sck)
				sdo_shift = {sdo_shift[14:0], 1'b0};
			adc_sdo = sdo_shift[15];
			prev = adc;
		end
	end

	// ------------------------------
	// i2c engine model
	task automatic drive_rsp(input logic board, input logic status);
		i2c_rsp_t r;
		r.status = status;
		r.data0 = model_word[15:8];
		r.data1 = model_word[7:0];
		if (board)
			i2c_sns = r;
		else
			i2c_pb = r;
	endtask

	initial begin : i2c_engine
		logic board;
		int hold;
		i2c_pb = '0;
		i2c_sns = '0;
		forever begin
			clk_wait();
			if (i2c_req.start_pb || i2c_req.start_sns) begin
				board = i2c_req.start_sns;
				rand_bits(3, hold);
				repeat (hold + 1) clk_wait();    // engine picks up the request
				drive_rsp(board, 1'b1);
				while (i2c_req.start_pb || i2c_req.start_sns)
					clk_wait();
				rand_bits(4, hold);
				repeat (hold + 2) clk_wait();    // bus transfer time
				drive_rsp(board, 1'b0);
			end
		end
	end

	// ------------------------------
	// watchdog, two frames of 64 bits at 16 clk per bit, per test
	initial begin : watchdog
		longint limit_ns;
		wait (n_frames > 0);
		limit_ns = longint'(n_frames) * 2 * MSG_LENGTH * 16 * CLK_NS + 200_000;
		#(limit_ns);
		$display("timeout: run did not finish within %0d ns", limit_ns);
		$display("** FAIL **");
		$finish;
	end

	// ------------------------------
	// main sequence
	initial begin
		n_reset = 1'b0;
		sck = 1'b0;
		din = 1'b0;
		frame_start = 1'b0;
		sent = '0;
		model_word = '0;
		exp_pay = '0;
		for (int i = 0; i < MAX_FRAMES * FIELDS; i++)
			stim[i] = 16'hffff;             // marks unused lines
		$readmemh("sim/cam_stimulus.txt", stim);
		while (n_frames < MAX_FRAMES && stim[n_frames * FIELDS] != 16'hffff)
			n_frames++;
		repeat (10) @(posedge clk);
		#DRIVE_NS;
		n_reset = 1'b1;
		repeat (4) clk_wait();
		for (int i = 0; i < n_frames; i++)
			run_frame(i);
		repeat (20) clk_wait();
		$display("frames %0d, responses checked %0d, errors %0d", n_frames, checked, errors);
		if (errors == 0 && checked == n_frames && n_frames > 0) begin
			$display("** PASS **");
		end else begin
			if (n_frames == 0)
				$display("the stimulus file holds no frames");
			else if (checked != n_frames)
				$display("not every response frame reached the checker");
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== sim/cam_checker.sv ====
`timescale 1ns/100ps

module cam_checker (
	input  logic clk,
	input  logic n_reset,
	input  logic sck,
	input  logic dout,
	input  logic ready,
	input  cam_pkg::adc_pins_t adc,
	input  logic spi_fifo_rst,
	input  logic acq_en,
	input  cam_pkg::i2c_req_t i2c_req,
	input  logic frame_start,            // new test frame begins
	input  cam_pkg::cam_frame_t sent,
	input  logic [15:0] exp_pay,
	output int errors,
	output int checked
);
	import cam_pkg::*;

	int err_cnt = 0;
	int frame_cnt = 0;
	int rst_cnt = 0;
	logic n_reset_q = 1'b0;
	logic sck_q = 1'b0;
	logic fifo_q = 1'b0;
	logic acq_exp = 1'b0;                // acquisition state the host asked for
	adc_pins_t adc_q;
	i2c_req_t req_q;
	logic [MSG_LENGTH-1:0] rsp;          // response as seen on dout
	int rx_cnt = 0;
	int cs_falls;
	int sck_rises;
	logic [15:0] sdi_rec;
	int sync_pulses;
	int sync_len;
	int fifo_pulses;
	int fifo_len;
	int pb_starts;
	int sns_starts;
	int kind_seen;

	assign errors = err_cnt;
	assign checked = frame_cnt;

	task automatic report_error(input string msg);
		err_cnt++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	// kind per opcode, 0 write 1 read 2 repeated start 3 word write
	function automatic int expected_kind(input logic [7:0] op);
		case (op)
			8'd7, 8'd10: return 0;
			8'd8, 8'd11: return 1;
			8'd9, 8'd12: return 2;
			default: return 3;
		endcase
	endfunction

	task automatic clear_counts();
		cs_falls = 0;
		sck_rises = 0;
		sdi_rec = '0;
		sync_pulses = 0;
		sync_len = 0;
		fifo_pulses = 0;
		fifo_len = 0;
		pb_starts = 0;
		sns_starts = 0;
		kind_seen = -1;
		rx_cnt = 0;
	endtask

	task automatic check_idle();
		adc_pins_t idle;
		idle.sck = 1'b0;
		idle.n_cs = 1'b1;
		idle.sdi = 1'b0;
		idle.n_sync_in = 1'b1;
		if (dout !== 1'b0 || ready !== 1'b0)
			report_error($sformatf("host side not idle, dout %b ready %b", dout, ready));
		if (adc !== idle)
			report_error($sformatf("adc pins not idle, got %b", adc));
		if (spi_fifo_rst !== 1'b0 || acq_en !== 1'b0)
			report_error($sformatf("fifo_rst %b acq_en %b at reset", spi_fifo_rst, acq_en));
		if (i2c_req.start_pb !== 1'b0 || i2c_req.start_sns !== 1'b0)
			report_error("i2c start bits high at reset");
	endtask

	// ------------------------------
	// one full response frame seen
	task automatic check_response();
		cam_frame_t want;
		logic [7:0] op;
		logic pb_op;
		logic sns_op;
		want = sent;                         // all but the payload echoed
		want.pay1 = exp_pay[15:8];
		want.pay0 = exp_pay[7:0];
		op = sent.opcode;
		pb_op = (op == 8'd7 || op == 8'd8 || op == 8'd9 || op == 8'd13);
		sns_op = (op == 8'd10 || op == 8'd11 || op == 8'd12);
		frame_cnt++;
		if (rsp !== want)
			report_error($sformatf("op %0d response %h, expected %h", op, rsp, want));
		if (op == 8'd4)
			acq_exp = 1'b1;
		else if (op == 8'd5)
			acq_exp = 1'b0;
		if (acq_en !== acq_exp)
			report_error($sformatf("op %0d acq_en %b, expected %b", op, acq_en, acq_exp));
		if (cs_falls != ((op == 8'd1) ? 1 : 0))
			report_error($sformatf("op %0d n_cs fell %0d times", op, cs_falls));
		if (sck_rises != ((op == 8'd1) ? ADC_WORD_BITS : 0))
			report_error($sformatf("op %0d saw %0d adc sck rises", op, sck_rises));
		if (op == 8'd1 && sdi_rec !== {sent.arg1, sent.arg0})
			report_error($sformatf("adc sdi word %h, expected %h", sdi_rec,
				{sent.arg1, sent.arg0}));
		if (sync_pulses != ((op == 8'd2) ? 1 : 0))
			report_error($sformatf("op %0d gave %0d sync pulses", op, sync_pulses));
		if (op == 8'd2 && sync_len != HALF_PERIOD_CYCLES)
			report_error($sformatf("sync pulse %0d cycles wide", sync_len));
		if (fifo_pulses != ((op == 8'd3) ? 1 : 0))
			report_error($sformatf("op %0d gave %0d fifo reset pulses", op, fifo_pulses));
		if (op == 8'd3 && fifo_len != HALF_PERIOD_CYCLES)
			report_error($sformatf("fifo reset pulse %0d cycles wide", fifo_len));
		if (pb_starts != int'(pb_op) || sns_starts != int'(sns_op))
			report_error($sformatf("op %0d starts pb %0d sns %0d", op, pb_starts, sns_starts));
		if ((pb_op || sns_op) && kind_seen != expected_kind(op))
			report_error($sformatf("op %0d i2c kind %0d, expected %0d", op, kind_seen,
				expected_kind(op)));
	endtask

	initial clear_counts();

	always @(posedge clk) begin
		// reset state, from the second reset edge to the first cycle after it
		if ((!n_reset && rst_cnt != 0) || (n_reset && !n_reset_q))
			check_idle();
		if (!n_reset)
			rst_cnt++;
		n_reset_q = n_reset;
		if (frame_start)
			clear_counts();

		// ------------------------------
		// adc, fifo and i2c activity
		if (adc_q.n_cs && !adc.n_cs)
			cs_falls++;
		if (!adc_q.sck && adc.sck) begin
			sck_rises++;
			sdi_rec = {sdi_rec[14:0], adc.sdi};   // bit the adc latches
		end
		if (adc_q.n_sync_in && !adc.n_sync_in)
			sync_pulses++;
		if (adc.n_sync_in === 1'b0)
			sync_len++;
		if (!fifo_q && spi_fifo_rst)
			fifo_pulses++;
		if (spi_fifo_rst === 1'b1)
			fifo_len++;
		if (!req_q.start_pb && i2c_req.start_pb) begin
			pb_starts++;
			kind_seen = int'(i2c_req.kind);
		end
		if (!req_q.start_sns && i2c_req.start_sns) begin
			sns_starts++;
			kind_seen = int'(i2c_req.kind);
		end

		// response bits, host samples at its sck fall
		if (ready && sck_q && !sck) begin
			rsp = {rsp[MSG_LENGTH-2:0], dout};
			rx_cnt++;
			if (rx_cnt == MSG_LENGTH) begin
				check_response();
				rx_cnt = 0;
			end
		end
		adc_q = adc;
		fifo_q = spi_fifo_rst;
		req_q = i2c_req;
		sck_q = sck;
	end

endmodule

// ==== logic/cam_top.sv ====
`timescale 1ns/100ps

module cam_top (
	input  logic clk,
	input  logic n_reset,
	input  logic sck,                    // host link
	input  logic din,
	output logic dout,
	output logic ready,
	output cam_pkg::adc_pins_t adc,      // adc control port
	input  logic adc_sdo,
	output logic spi_fifo_rst,
	output logic acq_en,
	output cam_pkg::i2c_req_t i2c_req,   // i2c engine handshake
	input  cam_pkg::i2c_rsp_t i2c_pb,
	input  cam_pkg::i2c_rsp_t i2c_sns
);
	import cam_pkg::*;

	// ------------------------------
	// link <-> dispatch
	cam_frame_t rx_frame;
	cam_frame_t tx_frame;
	logic frame_valid;
	logic resp_valid;

	// dispatch <-> adc port
	logic adc_go;
	logic sync_go;
	logic adc_done;
	logic [ADC_WORD_BITS-1:0] adc_word;
	logic [ADC_WORD_BITS-1:0] adc_result;

	// dispatch <-> i2c request
	logic i2c_go;
	i2c_kind_t i2c_kind;
	logic i2c_board;
	logic i2c_done;
	logic [15:0] i2c_data;

	host_link u_link (
		.clk         (clk),
		.n_reset     (n_reset),
		.sck         (sck),
		.din         (din),
		.dout        (dout),
		.ready       (ready),
		.rx_frame    (rx_frame),
		.frame_valid (frame_valid),
		.tx_frame    (tx_frame),
		.resp_valid  (resp_valid)
	);

	cam_dispatch u_dispatch (
		.clk          (clk),
		.n_reset      (n_reset),
		.rx_frame     (rx_frame),
		.frame_valid  (frame_valid),
		.tx_frame     (tx_frame),
		.resp_valid   (resp_valid),
		.adc_go       (adc_go),
		.sync_go      (sync_go),
		.adc_word     (adc_word),
		.adc_done     (adc_done),
		.adc_result   (adc_result),
		.i2c_go       (i2c_go),
		.i2c_kind     (i2c_kind),
		.i2c_board    (i2c_board),
		.i2c_done     (i2c_done),
		.i2c_data     (i2c_data),
		.spi_fifo_rst (spi_fifo_rst),
		.acq_en       (acq_en)
	);

	adc_spi_port u_adc (
		.clk        (clk),
		.n_reset    (n_reset),
		.adc_go     (adc_go),
		.sync_go    (sync_go),
		.adc_word   (adc_word),
		.adc_done   (adc_done),
		.adc_result (adc_result),
		.adc        (adc),
		.adc_sdo    (adc_sdo)
	);

	i2c_request u_i2c (
		.clk       (clk),
		.n_reset   (n_reset),
		.i2c_go    (i2c_go),
		.i2c_kind  (i2c_kind),
		.i2c_board (i2c_board),
		.i2c_done  (i2c_done),
		.i2c_data  (i2c_data),
		.i2c_req   (i2c_req),
		.i2c_pb    (i2c_pb),
		.i2c_sns   (i2c_sns)
	);

endmodule

// ==== logic/i2c_request.sv ====
`timescale 1ns/100ps

module i2c_request (
	input  logic clk,
	input  logic n_reset,
	input  logic i2c_go,
	input  cam_pkg::i2c_kind_t i2c_kind,
	input  logic i2c_board,              // 0 power board, 1 sensor board
	output logic i2c_done,
	output logic [15:0] i2c_data,        // data0, data1
	output cam_pkg::i2c_req_t i2c_req,
	input  cam_pkg::i2c_rsp_t i2c_pb,
	input  cam_pkg::i2c_rsp_t i2c_sns
);
	import cam_pkg::*;

	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_WAIT_HIGH,  // start held until engine busy
		REQ_WAIT_LOW    // engine working
	} req_state_t;

	req_state_t state;
	logic board_q;
	i2c_rsp_t rsp_sel;
	logic finish;

	assign rsp_sel = board_q ? i2c_sns : i2c_pb;
	assign finish = (state == REQ_WAIT_LOW) && !rsp_sel.status;

	// read data captured as the engine drops status
	always_ff @(posedge clk) begin
		if (finish)
			i2c_data <= {rsp_sel.data0, rsp_sel.data1};
	end

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state <= REQ_IDLE;
			board_q <= 1'b0;
			i2c_done <= 1'b0;
			i2c_req.kind <= I2C_WRITE;
			i2c_req.start_pb <= 1'b0;
			i2c_req.start_sns <= 1'b0;
		end else begin
			i2c_done <= 1'b0;
			case (state)
				REQ_IDLE: begin
					if (i2c_go) begin
						i2c_req.kind <= i2c_kind;               // held through the request
						board_q <= i2c_board;
						i2c_req.start_pb <= !i2c_board;
						i2c_req.start_sns <= i2c_board;
						state <= REQ_WAIT_HIGH;
					end
				end
				REQ_WAIT_HIGH: begin
					if (rsp_sel.status) begin                   // engine busy so drop start
						i2c_req.start_pb <= 1'b0;
						i2c_req.start_sns <= 1'b0;
						state <= REQ_WAIT_LOW;
					end
				end
				REQ_WAIT_LOW: begin
					if (finish) begin
						i2c_done <= 1'b1;
						state <= REQ_IDLE;
					end
				end
				default: state <= REQ_IDLE;
			endcase
		end
	end

	// start only drops once the addressed engine reports busy
	a_start_until_busy: assert property (@(posedge clk) disable iff (!n_reset)
		!($fell(i2c_req.start_pb) && !$past(i2c_pb.status)) &&
		!($fell(i2c_req.start_sns) && !$past(i2c_sns.status)))
		else $error("i2c_request: start dropped before the engine went busy");

endmodule

// ==== logic/adc_spi_port.sv ====
`timescale 1ns/100ps

module adc_spi_port (
	input  logic clk,
	input  logic n_reset,
	input  logic adc_go,
	input  logic sync_go,
	input  logic [cam_pkg::ADC_WORD_BITS-1:0] adc_word,
	output logic adc_done,
	output logic [cam_pkg::ADC_WORD_BITS-1:0] adc_result,
	output cam_pkg::adc_pins_t adc,
	input  logic adc_sdo
);
	import cam_pkg::*;

	typedef enum logic [2:0] {
		ADC_IDLE,
		ADC_LEAD,   // n_cs low, before first rise
		ADC_HIGH,   // sck high half period
		ADC_LOW,    // sck low half period
		ADC_END,    // release n_cs
		ADC_SYNC    // n_sync_in pulse
	} adc_state_t;

	adc_state_t state;
	logic [DELAY_WIDTH-1:0] delay;
	logic [$clog2(ADC_WORD_BITS+1)-1:0] bit_cnt;
	logic [ADC_WORD_BITS-1:0] tx_shift;  // next sdi bit at [msb-1]
	logic delay_end;
	logic rise_now;

	assign delay_end = (delay == DELAY_WIDTH'(HALF_PERIOD_CYCLES - 1));
	assign rise_now = (state == ADC_LEAD || state == ADC_LOW) && delay_end;

	// ------------------------------
	// data shifters
	always_ff @(posedge clk) begin
		if (state == ADC_IDLE && adc_go)
			tx_shift <= adc_word;
		else if (state == ADC_HIGH && delay_end)
			tx_shift <= {tx_shift[ADC_WORD_BITS-2:0], 1'b0};
		if (rise_now)
			adc_result <= {adc_result[ADC_WORD_BITS-2:0], adc_sdo};   // sample at rise
	end

	// ------------------------------
	// exchange / sync fsm
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state <= ADC_IDLE;
			delay <= '0;
			bit_cnt <= '0;
			adc_done <= 1'b0;
			adc.sck <= 1'b0;
			adc.n_cs <= 1'b1;
			adc.sdi <= 1'b0;
			adc.n_sync_in <= 1'b1;
		end else begin
			adc_done <= 1'b0;
			case (state)
				ADC_IDLE: begin
					delay <= '0;
					if (adc_go) begin
						adc.n_cs <= 1'b0;
						adc.sdi <= adc_word[ADC_WORD_BITS-1];     // first bit ready
						bit_cnt <= '0;
						state <= ADC_LEAD;
					end else if (sync_go) begin
						adc.n_sync_in <= 1'b0;
						state <= ADC_SYNC;
					end
				end
				ADC_LEAD, ADC_LOW: begin
					delay <= delay + 1'b1;
					if (delay_end) begin
						delay <= '0;
						adc.sck <= 1'b1;
						bit_cnt <= bit_cnt + 1'b1;
						state <= ADC_HIGH;
					end
				end
				ADC_HIGH: begin
					delay <= delay + 1'b1;
					if (delay_end) begin
						delay <= '0;
						adc.sck <= 1'b0;
						if (bit_cnt == ADC_WORD_BITS) begin
							adc.sdi <= 1'b0;
							state <= ADC_END;
						end else begin
							adc.sdi <= tx_shift[ADC_WORD_BITS-2];    // next bit on fall
							state <= ADC_LOW;
						end
					end
				end
				ADC_END: begin
					adc.n_cs <= 1'b1;
					adc_done <= 1'b1;
					state <= ADC_IDLE;
				end
				ADC_SYNC: begin
					delay <= delay + 1'b1;
					// done goes out a cycle early so the response
					// lands with the n_sync_in release
					if (delay == DELAY_WIDTH'(HALF_PERIOD_CYCLES - 2))
						adc_done <= 1'b1;
					if (delay_end) begin
						adc.n_sync_in <= 1'b1;
						delay <= '0;
						state <= ADC_IDLE;
					end
				end
				default: state <= ADC_IDLE;
			endcase
		end
	end

	a_sck_in_cs: assert property (@(posedge clk) disable iff (!n_reset)
		$changed(adc.sck) |-> !adc.n_cs)
		else $error("adc_spi_port: sck moved with n_cs high");

endmodule

// ==== logic/cam_dispatch.sv ====
`timescale 1ns/100ps

module cam_dispatch (
	input  logic clk,
	input  logic n_reset,
	input  cam_pkg::cam_frame_t rx_frame,
	input  logic frame_valid,
	output cam_pkg::cam_frame_t tx_frame,
	output logic resp_valid,
	output logic adc_go,
	output logic sync_go,
	output logic [cam_pkg::ADC_WORD_BITS-1:0] adc_word,
	input  logic adc_done,
	input  logic [cam_pkg::ADC_WORD_BITS-1:0] adc_result,
	output logic i2c_go,
	output cam_pkg::i2c_kind_t i2c_kind,
	output logic i2c_board,              // 0 power board, 1 sensor board
	input  logic i2c_done,
	input  logic [15:0] i2c_data,        // data0, data1
	output logic spi_fifo_rst,
	output logic acq_en
);
	import cam_pkg::*;

	typedef enum logic [1:0] {
		DSP_IDLE,
		DSP_ADC,    // exchange or sync in adc_spi_port
		DSP_FIFO,   // timing the fifo reset pulse
		DSP_I2C
	} dsp_state_t;

	dsp_state_t state;
	cam_frame_t frame_q;                 // response under construction
	logic [DELAY_WIDTH-1:0] fifo_delay;
	logic is_i2c;
	logic i2c_read_op;
	logic take;
	logic any_go;

	assign take = (state == DSP_IDLE) && frame_valid;   // new frame accepted
	assign tx_frame = frame_q;

	// go pulses ride the frame_valid cycle
	assign adc_go = take && (rx_frame.opcode == OP_ADC_XFER);
	assign sync_go = take && (rx_frame.opcode == OP_ADC_SYNC);
	assign i2c_go = take && is_i2c;
	assign adc_word = {rx_frame.arg1, rx_frame.arg0};     // arg1 goes out first
	assign any_go = adc_go | sync_go | i2c_go;

	// ------------------------------
	// i2c opcode decode
	always_comb begin
		is_i2c = 1'b1;
		i2c_board = 1'b0;
		i2c_kind = I2C_WRITE;
		case (rx_frame.opcode)
			OP_PB_WRITE:      i2c_kind = I2C_WRITE;
			OP_PB_READ:       i2c_kind = I2C_READ;
			OP_PB_READ_RS:    i2c_kind = I2C_READ_RS;
			OP_PB_WORD_WRITE: i2c_kind = I2C_WORD_WRITE;       // fuel gauge
			OP_SNS_WRITE:     i2c_board = 1'b1;
			OP_SNS_READ: begin
				i2c_board = 1'b1;
				i2c_kind = I2C_READ;
			end
			OP_SNS_READ_RS: begin
				i2c_board = 1'b1;
				i2c_kind = I2C_READ_RS;
			end
			default: is_i2c = 1'b0;
		endcase
	end

	// writes echo their payload, reads report the bus data
	assign i2c_read_op = frame_q.opcode inside {OP_PB_READ, OP_PB_READ_RS,
		OP_SNS_READ, OP_SNS_READ_RS};

	// ------------------------------
	// response frame and payload fill
	always_ff @(posedge clk) begin
		if (take) begin
			frame_q <= rx_frame;                               // stx..etx copied
			if (rx_frame.opcode == OP_TEST) begin
				frame_q.pay1 <= TEST_PAY1;
				frame_q.pay0 <= TEST_PAY0;
			end else if (rx_frame.opcode == OP_VERSION) begin
				frame_q.pay1 <= VER_MAJ;
				frame_q.pay0 <= VER_MIN;
			end
		end else if (state == DSP_ADC && adc_done && frame_q.opcode == OP_ADC_XFER) begin
			{frame_q.pay1, frame_q.pay0} <= adc_result;
		end else if (state == DSP_I2C && i2c_done && i2c_read_op) begin
			{frame_q.pay1, frame_q.pay0} <= i2c_data;
		end
	end

	// ------------------------------
	// opcode fsm
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state <= DSP_IDLE;
			resp_valid <= 1'b0;
			spi_fifo_rst <= 1'b0;
			acq_en <= 1'b0;
			fifo_delay <= '0;
		end else begin
			resp_valid <= 1'b0;
			case (state)
				DSP_IDLE: begin
					if (frame_valid) begin
						case (rx_frame.opcode)
							OP_ADC_XFER, OP_ADC_SYNC: state <= DSP_ADC;
							OP_FIFO_RST: begin
								spi_fifo_rst <= 1'b1;
								fifo_delay <= '0;
								state <= DSP_FIFO;
							end
							OP_ACQ_START: begin
								acq_en <= 1'b1;                        // samples into fifo
								resp_valid <= 1'b1;
							end
							OP_ACQ_STOP: begin
								acq_en <= 1'b0;
								resp_valid <= 1'b1;
							end
							default: begin
								if (is_i2c)
									state <= DSP_I2C;
								else
									resp_valid <= 1'b1;                    // test, version, echo
							end
						endcase
					end
				end
				DSP_ADC: begin
					if (adc_done) begin
						resp_valid <= 1'b1;
						state <= DSP_IDLE;
					end
				end
				DSP_FIFO: begin
					fifo_delay <= fifo_delay + 1'b1;
					if (fifo_delay == DELAY_WIDTH'(HALF_PERIOD_CYCLES - 1)) begin
						spi_fifo_rst <= 1'b0;
						resp_valid <= 1'b1;
						state <= DSP_IDLE;
					end
				end
				DSP_I2C: begin
					if (i2c_done) begin                          // may wait indefinitely
						resp_valid <= 1'b1;
						state <= DSP_IDLE;
					end
				end
				default: state <= DSP_IDLE;
			endcase
		end
	end

	// one operation per frame, nothing new until the response goes out
	a_one_go: assert property (@(posedge clk) disable iff (!n_reset)
		any_go |=> (!any_go throughout resp_valid[->1]))
		else $error("cam_dispatch: second go pulse before response");

endmodule

// ==== logic/host_link.sv ====
`timescale 1ns/100ps

module host_link (
	input  logic clk,
	input  logic n_reset,
	input  logic sck,                    // host serial clock
	input  logic din,
	output logic dout,
	output logic ready,                  // response waiting for the host
	output cam_pkg::cam_frame_t rx_frame,
	output logic frame_valid,
	input  cam_pkg::cam_frame_t tx_frame,
	input  logic resp_valid
);
	import cam_pkg::*;

	typedef enum logic [1:0] {
		LINK_RX,    // shifting in a frame
		LINK_WAIT,  // dispatch busy, sck ignored
		LINK_TX     // host clocking out the response
	} link_state_t;

	link_state_t state;
	logic sck_meta;                      // first sync flop
	logic sck_sync;                      // second sync flop
	logic sck_rise;
	logic sck_fall;
	logic last_bit;
	logic [MSG_LENGTH-1:0] shift_reg;    // shared rx/tx frame, msb first
	logic [BIT_CNT_WIDTH-1:0] bit_cnt;

	// ------------------------------
	// sck synchronizer
	always_ff @(posedge clk) begin
		sck_meta <= sck;
		sck_sync <= sck_meta;
	end

	assign sck_rise = sck_meta & ~sck_sync;   // acted on at the second clk
	assign sck_fall = ~sck_meta & sck_sync;
	assign last_bit = (bit_cnt == BIT_CNT_WIDTH'(MSG_LENGTH));
	assign rx_frame = cam_frame_t'(shift_reg);

	// frame data, shifts in din on every active rise
	always_ff @(posedge clk) begin
		if (state == LINK_WAIT && resp_valid)
			shift_reg <= tx_frame;                            // load response
		else if (state != LINK_WAIT && sck_rise)
			shift_reg <= {shift_reg[MSG_LENGTH-2:0], din};
	end

	// ------------------------------
	// receive / respond fsm
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state <= LINK_RX;
			bit_cnt <= '0;
			dout <= 1'b0;
			ready <= 1'b0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;                          // single cycle pulse
			case (state)
				LINK_RX: begin
					if (sck_rise)
						bit_cnt <= bit_cnt + 1'b1;
					if (sck_fall && last_bit) begin               // bit 64 done
						bit_cnt <= '0;
						frame_valid <= 1'b1;
						state <= LINK_WAIT;
					end
				end
				LINK_WAIT: begin
					if (resp_valid) begin
						ready <= 1'b1;
						state <= LINK_TX;
					end
				end
				LINK_TX: begin
					if (sck_rise) begin
						dout <= shift_reg[MSG_LENGTH-1];          // msb out first
						bit_cnt <= bit_cnt + 1'b1;
					end
					if (sck_fall && last_bit) begin
						dout <= 1'b0;                             // idle low between frames
						ready <= 1'b0;
						bit_cnt <= '0;
						state <= LINK_RX;
					end
				end
				default: state <= LINK_RX;
			endcase
		end
	end

	// dispatch must only answer a frame that was handed over
	a_resp_in_wait: assert property (@(posedge clk) disable iff (!n_reset)
		resp_valid |-> state == LINK_WAIT)
		else $error("host_link: resp_valid while not waiting");

endmodule

// ==== logic/cam_pkg.sv ====
package cam_pkg;

	// ------------------------------
	// frame and counter sizes
	localparam int MSG_LENGTH = 64;          // bits per host frame
	localparam int BIT_CNT_WIDTH = 7;        // wide enough to hold 64
	localparam int ADC_WORD_BITS = 16;       // one control-port exchange
	localparam int HALF_PERIOD_CYCLES = 21;  // spi half period, sync and fifo pulse
	localparam int DELAY_WIDTH = 5;          // delay counter width

	// ------------------------------
	// opcodes
	localparam logic [7:0] OP_TEST          = 8'd0;   // test word readback
	localparam logic [7:0] OP_ADC_XFER      = 8'd1;   // adc control port exchange
	localparam logic [7:0] OP_ADC_SYNC      = 8'd2;   // adc sync pulse
	localparam logic [7:0] OP_FIFO_RST      = 8'd3;   // sample fifo reset
	localparam logic [7:0] OP_ACQ_START     = 8'd4;
	localparam logic [7:0] OP_ACQ_STOP      = 8'd5;
	localparam logic [7:0] OP_PB_WRITE      = 8'd7;   // power board
	localparam logic [7:0] OP_PB_READ       = 8'd8;
	localparam logic [7:0] OP_PB_READ_RS    = 8'd9;
	localparam logic [7:0] OP_SNS_WRITE     = 8'd10;  // sensor board
	localparam logic [7:0] OP_SNS_READ      = 8'd11;
	localparam logic [7:0] OP_SNS_READ_RS   = 8'd12;
	localparam logic [7:0] OP_PB_WORD_WRITE = 8'd13;  // fuel gauge word write
	localparam logic [7:0] OP_VERSION       = 8'd16;

	// fixed payloads
	localparam logic [7:0] TEST_PAY1 = 8'hAA;
	localparam logic [7:0] TEST_PAY0 = 8'h55;
	localparam logic [7:0] VER_MAJ = 8'h23;  // hardware rev 2.3
	localparam logic [7:0] VER_MIN = 8'hD0;  // development build

	// ------------------------------
	// types
	typedef enum logic [3:0] {
		I2C_WRITE      = 4'd0,
		I2C_READ       = 4'd1,
		I2C_READ_RS    = 4'd2,  // read with repeated start
		I2C_WORD_WRITE = 4'd3
	} i2c_kind_t;

	typedef struct packed {
		logic [7:0] stx;     // first on the wire
		logic [7:0] opcode;
		logic [7:0] arg1;
		logic [7:0] arg0;
		logic [7:0] pay1;
		logic [7:0] pay0;
		logic [7:0] cs;      // xor checksum, not checked
		logic [7:0] etx;
	} cam_frame_t;

	typedef struct packed {
		logic sck;
		logic n_cs;
		logic sdi;
		logic n_sync_in;
	} adc_pins_t;

	typedef struct packed {
		i2c_kind_t kind;
		logic start_pb;
		logic start_sns;
	} i2c_req_t;

	typedef struct packed {
		logic status;       // high while engine busy
		logic [7:0] data0;
		logic [7:0] data1;
	} i2c_rsp_t;

endpackage
